// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int BR_ADDR_W   = 12,
    parameter int SRAM_ADDR_W = 13,
    parameter int REG_ADDR_W  = 5
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             idu_vld,
    input  wire exec_op_pkg::alu_op_e       idu_op,
    input  wire [exec_op_pkg::XLEN-1:0]     idu_src1,
    input  wire [exec_op_pkg::XLEN-1:0]     idu_src2,
    input  wire [exec_op_pkg::XLEN-1:0]     idu_imm,
    input  wire [exec_op_pkg::XLEN-1:0]     idu_pc,
    input  wire                             idu_wb_vld_in,
    input  wire [REG_ADDR_W-1:0]            idu_wb_addr_in,
    input  wire                             lsu_rdy,
    output logic                            idu_rdy,
    output logic                            idu_flush_vld,
    output logic                            idu_wb_vld,
    output logic [REG_ADDR_W-1:0]           idu_wb_addr,
    output logic [exec_op_pkg::XLEN-1:0]    idu_wb_data,
    output logic                            idu_ld_vld,
    output logic                            ifu_br_vld,
    output logic [BR_ADDR_W-1:0]            ifu_br_addr,
    output logic                            lsu_vld,
    output logic                            lsu_wb_vld,
    output logic [REG_ADDR_W-1:0]           lsu_wb_addr,
    output logic [exec_op_pkg::XLEN-1:0]    lsu_wb_data,
    output logic [exec_op_pkg::XLEN-1:0]    lsu_src2,
    output exec_op_pkg::mem_op_e            lsu_mem_op,
    output logic [SRAM_ADDR_W-1:0]          lsu_addr,
    output logic                            lsu_ld_iram,
    output logic                            lsu_ld_wram,
    output logic                            lsu_ld_oram,
    output logic                            lsu_st_iram,
    output logic                            lsu_st_wram,
    output logic                            lsu_st_oram
);

    logic                           fire;
    logic                           is_branch;
    logic                           is_jump;
    logic                           is_load;
    logic                           is_store;
    exec_op_pkg::mem_op_e           mem_op;
    logic [exec_op_pkg::XLEN-1:0]   alu_data;
    logic                           br_taken;
    logic [BR_ADDR_W-1:0]           br_target;
    logic [SRAM_ADDR_W-1:0]         mem_addr;
    sram_map_pkg::sram_type_e       mem_type;

    assign idu_rdy       = lsu_rdy;
    assign idu_flush_vld = ifu_br_vld;

    // same cycle writeback to decode
    assign idu_wb_vld  = fire & idu_wb_vld_in;
    assign idu_wb_addr = idu_wb_addr_in;
    assign idu_wb_data = alu_data;
    assign idu_ld_vld  = is_load;

    alu_decode u_decode (
        .op        (idu_op),
        .vld       (idu_vld),
        .lsu_rdy   (lsu_rdy),
        .br_vld    (ifu_br_vld),
        .fire      (fire),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .is_load   (is_load),
        .is_store  (is_store),
        .mem_op    (mem_op)
    );

    alu_execute #(
        .SRAM_ADDR_W (SRAM_ADDR_W),
        .BR_ADDR_W   (BR_ADDR_W)
    ) u_execute (
        .op        (idu_op),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .is_load   (is_load),
        .is_store  (is_store),
        .src1      (idu_src1),
        .src2      (idu_src2),
        .imm       (idu_imm),
        .pc        (idu_pc),
        .alu_data  (alu_data),
        .br_taken  (br_taken),
        .br_target (br_target),
        .mem_addr  (mem_addr),
        .mem_type  (mem_type)
    );

    alu_result #(
        .SRAM_ADDR_W (SRAM_ADDR_W),
        .BR_ADDR_W   (BR_ADDR_W),
        .REG_ADDR_W  (REG_ADDR_W)
    ) u_result (
        .clk         (clk),
        .arst_n      (arst_n),
        .fire        (fire),
        .lsu_rdy     (lsu_rdy),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .is_load     (is_load),
        .is_store    (is_store),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .alu_data    (alu_data),
        .wb_vld_in   (idu_wb_vld_in),
        .wb_addr_in  (idu_wb_addr_in),
        .src2        (idu_src2),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_type    (mem_type),
        .br_vld      (ifu_br_vld),
        .br_addr     (ifu_br_addr),
        .lsu_vld     (lsu_vld),
        .lsu_wb_vld  (lsu_wb_vld),
        .lsu_wb_addr (lsu_wb_addr),
        .lsu_wb_data (lsu_wb_data),
        .lsu_src2    (lsu_src2),
        .lsu_mem_op  (lsu_mem_op),
        .lsu_addr    (lsu_addr),
        .lsu_ld_iram (lsu_ld_iram),
        .lsu_ld_wram (lsu_ld_wram),
        .lsu_ld_oram (lsu_ld_oram),
        .lsu_st_iram (lsu_st_iram),
        .lsu_st_wram (lsu_st_wram),
        .lsu_st_oram (lsu_st_oram)
    );

endmodule

`default_nettype wire

// File: alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
    input  wire exec_op_pkg::alu_op_e op,
    input  wire                       vld,
    input  wire                       lsu_rdy,
    input  wire                       br_vld,
    output logic                      fire,
    output logic                      is_branch,
    output logic                      is_jump,
    output logic                      is_load,
    output logic                      is_store,
    output exec_op_pkg::mem_op_e      mem_op
);

    // slot after a redirect is squashed
    assign fire = vld & lsu_rdy & ~br_vld;

    always_comb begin
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        mem_op    = exec_op_pkg::mem_none;
        case (op)
            exec_op_pkg::op_beq,
            exec_op_pkg::op_bne,
            exec_op_pkg::op_blt,
            exec_op_pkg::op_bge,
            exec_op_pkg::op_bltu,
            exec_op_pkg::op_bgeu: begin
                is_branch = 1'b1;
            end
            exec_op_pkg::op_jal,
            exec_op_pkg::op_jalr: begin
                is_jump = 1'b1;
            end
            exec_op_pkg::op_lb: begin
                is_load = 1'b1;
                mem_op  = exec_op_pkg::mem_lb;
            end
            exec_op_pkg::op_lh: begin
                is_load = 1'b1;
                mem_op  = exec_op_pkg::mem_lh;
            end
            exec_op_pkg::op_lw: begin
                is_load = 1'b1;
                mem_op  = exec_op_pkg::mem_lw;
            end
            exec_op_pkg::op_lbu: begin
                is_load = 1'b1;
                mem_op  = exec_op_pkg::mem_lbu;
            end
            exec_op_pkg::op_lhu: begin
                is_load = 1'b1;
                mem_op  = exec_op_pkg::mem_lhu;
            end
            exec_op_pkg::op_sb: begin
                is_store = 1'b1;
                mem_op   = exec_op_pkg::mem_sb;
            end
            exec_op_pkg::op_sh: begin
                is_store = 1'b1;
                mem_op   = exec_op_pkg::mem_sh;
            end
            exec_op_pkg::op_sw: begin
                is_store = 1'b1;
                mem_op   = exec_op_pkg::mem_sw;
            end
            default: begin
                mem_op = exec_op_pkg::mem_none;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute #(
    parameter int SRAM_ADDR_W = 13,
    parameter int BR_ADDR_W   = 12
) (
    input  wire exec_op_pkg::alu_op_e               op,
    input  wire                                     is_branch,
    input  wire                                     is_jump,
    input  wire                                     is_load,
    input  wire                                     is_store,
    input  wire [exec_op_pkg::XLEN-1:0]             src1,
    input  wire [exec_op_pkg::XLEN-1:0]             src2,
    input  wire [exec_op_pkg::XLEN-1:0]             imm,
    input  wire [exec_op_pkg::XLEN-1:0]             pc,
    output logic [exec_op_pkg::XLEN-1:0]            alu_data,
    output logic                                    br_taken,
    output logic [BR_ADDR_W-1:0]                    br_target,
    output logic [SRAM_ADDR_W-1:0]                  mem_addr,
    output sram_map_pkg::sram_type_e                mem_type
);

    logic [exec_op_pkg::XLEN-1:0]    sum;
    logic [exec_op_pkg::XLEN-1:0]    st_sum;
    logic [exec_op_pkg::XLEN-1:0]    pc_imm;
    logic [exec_op_pkg::XLEN-1:0]    pc_src2;
    logic [exec_op_pkg::XLEN-1:0]    link_pc;
    logic [exec_op_pkg::XLEN-1:0]    jump_pc;
    logic [exec_op_pkg::XLEN-1:0]    target_pc;
    logic [exec_op_pkg::XLEN-1:0]    eff_addr;
    logic [exec_op_pkg::SHAMT_W-1:0] shamt;
    logic                            lt_s;
    logic                            lt_u;
    logic                            eq;
    logic                            cond;

    assign sum     = src1 + src2;
    assign st_sum  = src1 + imm;
    assign pc_imm  = pc + imm;
    assign pc_src2 = pc + src2;
    assign link_pc = pc + 32'd4;
    assign shamt   = src2[exec_op_pkg::SHAMT_W-1:0];

    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;
    assign eq   = src1 == src2;

    always_comb begin
        case (op)
            exec_op_pkg::op_add:   alu_data = sum;
            exec_op_pkg::op_sub:   alu_data = src1 - src2;
            exec_op_pkg::op_slt:   alu_data = {{(exec_op_pkg::XLEN-1){1'b0}}, lt_s};
            exec_op_pkg::op_sltu:  alu_data = {{(exec_op_pkg::XLEN-1){1'b0}}, lt_u};
            exec_op_pkg::op_xor:   alu_data = src1 ^ src2;
            exec_op_pkg::op_or:    alu_data = src1 | src2;
            exec_op_pkg::op_and:   alu_data = src1 & src2;
            exec_op_pkg::op_sll:   alu_data = src1 << shamt;
            exec_op_pkg::op_srl:   alu_data = src1 >> shamt;
            exec_op_pkg::op_sra:   alu_data = $unsigned($signed(src1) >>> shamt);
            // upper immediate arrives already shifted in src2
            exec_op_pkg::op_lui:   alu_data = src2;
            exec_op_pkg::op_auipc: alu_data = pc_src2;
            exec_op_pkg::op_jal,
            exec_op_pkg::op_jalr:  alu_data = link_pc;
            default:               alu_data = '0;
        endcase
    end

    always_comb begin
        case (op)
            exec_op_pkg::op_beq:  cond = eq;
            exec_op_pkg::op_bne:  cond = ~eq;
            exec_op_pkg::op_blt:  cond = lt_s;
            exec_op_pkg::op_bge:  cond = ~lt_s;
            exec_op_pkg::op_bltu: cond = lt_u;
            exec_op_pkg::op_bgeu: cond = ~lt_u;
            default:              cond = 1'b0;
        endcase
    end

    assign br_taken = is_branch & cond;

    // jalr adds to the register, jal to the pc
    assign jump_pc   = (op == exec_op_pkg::op_jalr) ? sum : pc_src2;
    assign target_pc = is_jump ? jump_pc : pc_imm;
    assign br_target = target_pc[BR_ADDR_W-1:0];

    always_comb begin
        if (is_store) begin
            eff_addr = st_sum;
        end else if (is_load) begin
            eff_addr = sum;
        end else begin
            eff_addr = '0;
        end
    end

    assign mem_addr = eff_addr[SRAM_ADDR_W-1:0];
    assign mem_type = sram_map_pkg::addr_type(eff_addr, SRAM_ADDR_W);

endmodule

`default_nettype wire

// File: alu_result.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result #(
    parameter int SRAM_ADDR_W = 13,
    parameter int BR_ADDR_W   = 12,
    parameter int REG_ADDR_W  = 5
) (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire                                 fire,
    input  wire                                 lsu_rdy,
    input  wire                                 is_branch,
    input  wire                                 is_jump,
    input  wire                                 is_load,
    input  wire                                 is_store,
    input  wire                                 br_taken,
    input  wire [BR_ADDR_W-1:0]                 br_target,
    input  wire [exec_op_pkg::XLEN-1:0]         alu_data,
    input  wire                                 wb_vld_in,
    input  wire [REG_ADDR_W-1:0]                wb_addr_in,
    input  wire [exec_op_pkg::XLEN-1:0]         src2,
    input  wire exec_op_pkg::mem_op_e           mem_op,
    input  wire [SRAM_ADDR_W-1:0]               mem_addr,
    input  wire sram_map_pkg::sram_type_e       mem_type,
    output logic                                br_vld,
    output logic [BR_ADDR_W-1:0]                br_addr,
    output logic                                lsu_vld,
    output logic                                lsu_wb_vld,
    output logic [REG_ADDR_W-1:0]               lsu_wb_addr,
    output logic [exec_op_pkg::XLEN-1:0]        lsu_wb_data,
    output logic [exec_op_pkg::XLEN-1:0]        lsu_src2,
    output exec_op_pkg::mem_op_e                lsu_mem_op,
    output logic [SRAM_ADDR_W-1:0]              lsu_addr,
    output logic                                lsu_ld_iram,
    output logic                                lsu_ld_wram,
    output logic                                lsu_ld_oram,
    output logic                                lsu_st_iram,
    output logic                                lsu_st_wram,
    output logic                                lsu_st_oram
);

    logic       lsu_vld_nxt;
    logic       lsu_wb_vld_nxt;
    logic       br_vld_nxt;
    logic [2:0] sel;

    // branches end here, jumps still go on to the lsu
    assign lsu_vld_nxt    = (fire & ~is_branch) | (lsu_vld & ~lsu_rdy);
    assign lsu_wb_vld_nxt = (fire & ~is_branch & wb_vld_in) | (lsu_wb_vld & ~lsu_rdy);

    // br_vld blocks fire, so this is a single cycle pulse
    assign br_vld_nxt = fire & (is_jump | br_taken);

    assign sel = sram_map_pkg::sram_onehot(mem_type);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lsu_vld    <= 1'b0;
            lsu_wb_vld <= 1'b0;
            br_vld     <= 1'b0;
        end else begin
            lsu_vld    <= lsu_vld_nxt;
            lsu_wb_vld <= lsu_wb_vld_nxt;
            br_vld     <= br_vld_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            br_addr     <= br_target;
            lsu_wb_addr <= wb_addr_in;
            lsu_wb_data <= alu_data;
            lsu_src2    <= src2;
            lsu_mem_op  <= mem_op;
            lsu_addr    <= mem_addr;
            lsu_ld_iram <= is_load & sel[0];
            lsu_ld_wram <= is_load & sel[1];
            lsu_ld_oram <= is_load & sel[2];
            lsu_st_iram <= is_store & sel[0];
            lsu_st_wram <= is_store & sel[1];
            lsu_st_oram <= is_store & sel[2];
        end
    end

endmodule

`default_nettype wire

// File: exec_op_pkg.sv
`default_nettype none

package exec_op_pkg;

    // data path and pc width
    parameter int XLEN = 32;
    parameter int SHAMT_W = 5;

    typedef enum logic [4:0] {
        op_none,
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr
    } alu_op_e;

    // access kind seen by the load/store unit
    typedef enum logic [3:0] {
        mem_none,
        mem_lb,
        mem_lh,
        mem_lw,
        mem_lbu,
        mem_lhu,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_e;

endpackage

`default_nettype wire

// File: filelist.f
exec_op_pkg.sv
sram_map_pkg.sv
alu_decode.sv
alu_execute.sv
alu_result.sv
alu.sv
tb_alu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the alu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_alu -f filelist.f --Mdir obj_dir -o tb_alu_sim

./obj_dir/tb_alu_sim > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: sram_map_pkg.sv
`default_nettype none

package sram_map_pkg;

    parameter int TYPE_W = 2;

    // two bits just above the sram word address
    typedef enum logic [TYPE_W-1:0] {
        sram_iram = 2'b00,
        sram_oram = 2'b01,
        sram_wram = 2'b10,
        sram_none = 2'b11
    } sram_type_e;

    function automatic sram_type_e addr_type(input logic [exec_op_pkg::XLEN-1:0] addr,
                                             input int unsigned field_w);
        return sram_type_e'(addr[field_w +: TYPE_W]);
    endfunction

    // one-hot select, bit 0 iram, bit 1 wram, bit 2 oram
    function automatic logic [2:0] sram_onehot(input sram_type_e sel);
        return {sel == sram_oram, sel == sram_wram, sel == sram_iram};
    endfunction

endpackage

`default_nettype wire

// File: tb_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu;

    localparam int BR_ADDR_W   = 12;
    localparam int SRAM_ADDR_W = 13;
    localparam int REG_ADDR_W  = 5;

    logic                          clk;
    logic                          arst_n;
    logic                          idu_vld;
    exec_op_pkg::alu_op_e          idu_op;
    logic [31:0]                   idu_src1;
    logic [31:0]                   idu_src2;
    logic [31:0]                   idu_imm;
    logic [31:0]                   idu_pc;
    logic                          idu_wb_vld_in;
    logic [REG_ADDR_W-1:0]         idu_wb_addr_in;
    logic                          lsu_rdy;
    logic                          idu_rdy;
    logic                          idu_flush_vld;
    logic                          idu_wb_vld;
    logic [REG_ADDR_W-1:0]         idu_wb_addr;
    logic [31:0]                   idu_wb_data;
    logic                          idu_ld_vld;
    logic                          ifu_br_vld;
    logic [BR_ADDR_W-1:0]          ifu_br_addr;
    logic                          lsu_vld;
    logic                          lsu_wb_vld;
    logic [REG_ADDR_W-1:0]         lsu_wb_addr;
    logic [31:0]                   lsu_wb_data;
    logic [31:0]                   lsu_src2;
    exec_op_pkg::mem_op_e          lsu_mem_op;
    logic [SRAM_ADDR_W-1:0]        lsu_addr;
    logic                          lsu_ld_iram;
    logic                          lsu_ld_wram;
    logic                          lsu_ld_oram;
    logic                          lsu_st_iram;
    logic                          lsu_st_wram;
    logic                          lsu_st_oram;

    integer seed;
    int     errors;
    int     tests;
    int     errs_at_start;
    logic   timed_out;

    // reference model, combinational part
    logic                   m_fire;
    logic                   m_branch;
    logic                   m_jump;
    logic                   m_load;
    logic                   m_store;
    logic                   m_data_op;
    logic                   m_taken;
    logic [31:0]            m_data;
    logic [31:0]            m_target;
    logic [31:0]            m_eff;
    logic [2:0]             m_sel;
    // reference model, registered part
    logic                   m_lsu_vld;
    logic                   m_lsu_wb_vld;
    logic                   m_br_vld;
    logic [BR_ADDR_W-1:0]   m_br_addr;
    logic [REG_ADDR_W-1:0]  m_wb_addr;
    logic [31:0]            m_wb_data;
    logic                   m_has_data;
    logic [31:0]            m_src2;
    logic                   m_store_q;
    logic                   m_mem_q;
    exec_op_pkg::mem_op_e   m_mem_op;
    logic [SRAM_ADDR_W-1:0] m_addr;
    logic [2:0]             m_ld;
    logic [2:0]             m_st;

    exec_op_pkg::alu_op_e alu_ops [12] = '{
        exec_op_pkg::op_add, exec_op_pkg::op_sub, exec_op_pkg::op_slt, exec_op_pkg::op_sltu,
        exec_op_pkg::op_xor, exec_op_pkg::op_or, exec_op_pkg::op_and, exec_op_pkg::op_sll,
        exec_op_pkg::op_srl, exec_op_pkg::op_sra, exec_op_pkg::op_lui, exec_op_pkg::op_auipc
    };
    exec_op_pkg::alu_op_e br_ops [6] = '{
        exec_op_pkg::op_beq, exec_op_pkg::op_bne, exec_op_pkg::op_blt,
        exec_op_pkg::op_bge, exec_op_pkg::op_bltu, exec_op_pkg::op_bgeu
    };
    exec_op_pkg::alu_op_e mem_ops [8] = '{
        exec_op_pkg::op_lb, exec_op_pkg::op_lh, exec_op_pkg::op_lw, exec_op_pkg::op_lbu,
        exec_op_pkg::op_lhu, exec_op_pkg::op_sb, exec_op_pkg::op_sh, exec_op_pkg::op_sw
    };

    alu #(
        .BR_ADDR_W   (BR_ADDR_W),
        .SRAM_ADDR_W (SRAM_ADDR_W),
        .REG_ADDR_W  (REG_ADDR_W)
    ) alu_inst (
        .clk (clk), .arst_n (arst_n), .idu_vld (idu_vld), .idu_op (idu_op),
        .idu_src1 (idu_src1), .idu_src2 (idu_src2), .idu_imm (idu_imm), .idu_pc (idu_pc),
        .idu_wb_vld_in (idu_wb_vld_in), .idu_wb_addr_in (idu_wb_addr_in), .lsu_rdy (lsu_rdy),
        .idu_rdy (idu_rdy), .idu_flush_vld (idu_flush_vld), .idu_wb_vld (idu_wb_vld),
        .idu_wb_addr (idu_wb_addr), .idu_wb_data (idu_wb_data), .idu_ld_vld (idu_ld_vld),
        .ifu_br_vld (ifu_br_vld), .ifu_br_addr (ifu_br_addr), .lsu_vld (lsu_vld),
        .lsu_wb_vld (lsu_wb_vld), .lsu_wb_addr (lsu_wb_addr), .lsu_wb_data (lsu_wb_data),
        .lsu_src2 (lsu_src2), .lsu_mem_op (lsu_mem_op), .lsu_addr (lsu_addr),
        .lsu_ld_iram (lsu_ld_iram), .lsu_ld_wram (lsu_ld_wram), .lsu_ld_oram (lsu_ld_oram),
        .lsu_st_iram (lsu_st_iram), .lsu_st_wram (lsu_st_wram), .lsu_st_oram (lsu_st_oram)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] alu_value(input exec_op_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] pc);
        case (op)
            exec_op_pkg::op_add:   return a + b;
            exec_op_pkg::op_sub:   return a - b;
            exec_op_pkg::op_slt:   return {31'd0, $signed(a) < $signed(b)};
            exec_op_pkg::op_sltu:  return {31'd0, a < b};
            exec_op_pkg::op_xor:   return a ^ b;
            exec_op_pkg::op_or:    return a | b;
            exec_op_pkg::op_and:   return a & b;
            exec_op_pkg::op_sll:   return a << b[4:0];
            exec_op_pkg::op_srl:   return a >> b[4:0];
            exec_op_pkg::op_sra:   return $signed(a) >>> b[4:0];
            exec_op_pkg::op_lui:   return b;
            exec_op_pkg::op_auipc: return pc + b;
            exec_op_pkg::op_jal,
            exec_op_pkg::op_jalr:  return pc + 32'd4;
            default:               return 32'd0;
        endcase
    endfunction

    function automatic logic branch_taken(input exec_op_pkg::alu_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
        case (op)
            exec_op_pkg::op_beq:  return a == b;
            exec_op_pkg::op_bne:  return a != b;
            exec_op_pkg::op_blt:  return $signed(a) < $signed(b);
            exec_op_pkg::op_bge:  return $signed(a) >= $signed(b);
            exec_op_pkg::op_bltu: return a < b;
            exec_op_pkg::op_bgeu: return a >= b;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic exec_op_pkg::mem_op_e access_kind(input exec_op_pkg::alu_op_e op);
        case (op)
            exec_op_pkg::op_lb:  return exec_op_pkg::mem_lb;
            exec_op_pkg::op_lh:  return exec_op_pkg::mem_lh;
            exec_op_pkg::op_lw:  return exec_op_pkg::mem_lw;
            exec_op_pkg::op_lbu: return exec_op_pkg::mem_lbu;
            exec_op_pkg::op_lhu: return exec_op_pkg::mem_lhu;
            exec_op_pkg::op_sb:  return exec_op_pkg::mem_sb;
            exec_op_pkg::op_sh:  return exec_op_pkg::mem_sh;
            exec_op_pkg::op_sw:  return exec_op_pkg::mem_sw;
            default:             return exec_op_pkg::mem_none;
        endcase
    endfunction

    assign m_fire    = idu_vld && lsu_rdy && !m_br_vld;
    assign m_branch  = idu_op inside {exec_op_pkg::op_beq, exec_op_pkg::op_bne,
                                      exec_op_pkg::op_blt, exec_op_pkg::op_bge,
                                      exec_op_pkg::op_bltu, exec_op_pkg::op_bgeu};
    assign m_jump    = idu_op inside {exec_op_pkg::op_jal, exec_op_pkg::op_jalr};
    assign m_load    = idu_op inside {exec_op_pkg::op_lb, exec_op_pkg::op_lh,
                                      exec_op_pkg::op_lw, exec_op_pkg::op_lbu,
                                      exec_op_pkg::op_lhu};
    assign m_store   = idu_op inside {exec_op_pkg::op_sb, exec_op_pkg::op_sh,
                                      exec_op_pkg::op_sw};
    assign m_data_op = !(m_branch || m_load || m_store || idu_op == exec_op_pkg::op_none);
    assign m_taken   = branch_taken(idu_op, idu_src1, idu_src2);
    assign m_data    = alu_value(idu_op, idu_src1, idu_src2, idu_pc);
    assign m_target  = (idu_op == exec_op_pkg::op_jal)  ? idu_pc + idu_src2 :
                       (idu_op == exec_op_pkg::op_jalr) ? idu_src1 + idu_src2 :
                       idu_pc + idu_imm;
    assign m_eff     = m_store ? idu_src1 + idu_imm : idu_src1 + idu_src2;

    // select order iram, wram, oram
    always_comb begin
        case (m_eff[SRAM_ADDR_W +: 2])
            2'b00:   m_sel = 3'b100;
            2'b01:   m_sel = 3'b001;
            2'b10:   m_sel = 3'b010;
            default: m_sel = 3'b000;
        endcase
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_lsu_vld    <= 1'b0;
            m_lsu_wb_vld <= 1'b0;
            m_br_vld     <= 1'b0;
        end else begin
            m_lsu_vld    <= (m_fire && !m_branch) || (m_lsu_vld && !lsu_rdy);
            m_lsu_wb_vld <= (m_fire && !m_branch && idu_wb_vld_in) || (m_lsu_wb_vld && !lsu_rdy);
            m_br_vld     <= m_fire && (m_jump || (m_branch && m_taken));
        end
    end

    always @(posedge clk) begin
        if (m_fire) begin
            m_br_addr  <= m_target[BR_ADDR_W-1:0];
            m_wb_addr  <= idu_wb_addr_in;
            m_wb_data  <= m_data;
            m_has_data <= m_data_op;
            m_src2     <= idu_src2;
            m_store_q  <= m_store;
            m_mem_q    <= m_load || m_store;
            m_mem_op   <= access_kind(idu_op);
            m_addr     <= m_eff[SRAM_ADDR_W-1:0];
            m_ld       <= m_load ? m_sel : 3'b000;
            m_st       <= m_store ? m_sel : 3'b000;
        end
    end

    task automatic log_error(input string msg);
        errors++;
        $display("error: %0d ns: %s", $time, msg);
    endtask

    a_rdy: assert property (@(posedge clk) idu_rdy == lsu_rdy)
        else log_error("idu_rdy does not follow lsu_rdy");
    a_valid: assert property (@(posedge clk) disable iff (!arst_n)
        lsu_vld == m_lsu_vld && lsu_wb_vld == m_lsu_wb_vld)
        else log_error("lsu_vld or lsu_wb_vld wrong");
    a_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        ifu_br_vld == m_br_vld && idu_flush_vld == m_br_vld)
        else log_error("ifu_br_vld or idu_flush_vld wrong");
    a_br_addr: assert property (@(posedge clk) disable iff (!arst_n)
        m_br_vld |-> ifu_br_addr == m_br_addr)
        else log_error("ifu_br_addr wrong");
    a_wb_vld: assert property (@(posedge clk) idu_wb_vld == (m_fire && idu_wb_vld_in))
        else log_error("idu_wb_vld wrong");
    a_wb_data: assert property (@(posedge clk) disable iff (!arst_n)
        (idu_vld && m_data_op) |-> (idu_wb_data == m_data && idu_wb_addr == idu_wb_addr_in))
        else log_error("idu_wb_data or idu_wb_addr wrong");
    a_ld_vld: assert property (@(posedge clk) disable iff (!arst_n) idu_ld_vld == m_load)
        else log_error("idu_ld_vld wrong");
    a_lsu_data: assert property (@(posedge clk) disable iff (!arst_n)
        (m_lsu_vld && m_has_data) |-> lsu_wb_data == m_wb_data)
        else log_error("lsu_wb_data wrong");
    a_lsu_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
        m_lsu_vld |-> (lsu_wb_addr == m_wb_addr && lsu_mem_op == m_mem_op
            && {lsu_ld_iram, lsu_ld_wram, lsu_ld_oram} == m_ld
            && {lsu_st_iram, lsu_st_wram, lsu_st_oram} == m_st))
        else log_error("lsu_wb_addr, lsu_mem_op or sram flags wrong");
    a_lsu_addr: assert property (@(posedge clk) disable iff (!arst_n)
        (m_lsu_vld && m_mem_q) |-> lsu_addr == m_addr)
        else log_error("lsu_addr wrong");
    a_lsu_src2: assert property (@(posedge clk) disable iff (!arst_n)
        (m_lsu_vld && m_store_q) |-> lsu_src2 == m_src2)
        else log_error("lsu_src2 wrong for store");
    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(lsu_vld) && !$past(lsu_rdy)) |-> (lsu_vld && lsu_wb_data == $past(lsu_wb_data)
            && lsu_addr == $past(lsu_addr) && lsu_mem_op == $past(lsu_mem_op)
            && lsu_src2 == $past(lsu_src2)))
        else log_error("lsu outputs changed under back-pressure");

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic issue(input exec_op_pkg::alu_op_e op, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] c, input logic [31:0] p);
        int          waited;
        logic [31:0] r;
        if (timed_out) begin
            return;
        end
        r = next_rand();
        idu_vld = 1'b1;
        idu_op = op;
        idu_src1 = a;
        idu_src2 = b;
        idu_imm = c;
        idu_pc = p;
        idu_wb_vld_in = (r[2:0] != 3'd0);
        idu_wb_addr_in = r[12:8];
        waited = 0;
        // a redirect pulse drops the slot, so keep presenting
        while (!(idu_rdy && !ifu_br_vld) && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (idu_rdy && !ifu_br_vld) begin
            @(negedge clk);
        end else begin
            timed_out = 1'b1;
        end
    endtask

    task automatic idle();
        idu_vld = 1'b0;
        idu_op = exec_op_pkg::op_none;
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - errs_at_start);
        errs_at_start = errors;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] addr;
        logic [31:0] spare;
        seed = 32'hc2ed88db;
        errors = 0;
        tests = 0;
        errs_at_start = 0;
        timed_out = 1'b0;
        clk = 1'b0;
        arst_n = 1'b0;
        idu_vld = 1'b0;
        idu_op = exec_op_pkg::op_none;
        idu_src1 = '0;
        idu_src2 = '0;
        idu_imm = '0;
        idu_pc = '0;
        idu_wb_vld_in = 1'b0;
        idu_wb_addr_in = '0;
        lsu_rdy = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        idle();
        end_test("reset");

        foreach (alu_ops[i]) begin
            repeat (4) begin
                issue(alu_ops[i], next_rand(), next_rand(), next_rand(), next_rand());
            end
        end
        idle();
        end_test("alu operations");

        // each branch is followed by an add that meets the pulse
        foreach (br_ops[i]) begin
            repeat (3) begin
                issue(br_ops[i], next_rand(), next_rand(), next_rand(), next_rand());
                issue(exec_op_pkg::op_add, next_rand(), next_rand(), 32'd0, 32'd0);
            end
            a = next_rand();
            issue(br_ops[i], a, a, next_rand(), next_rand());
            issue(exec_op_pkg::op_add, next_rand(), next_rand(), 32'd0, 32'd0);
        end
        idle();
        end_test("branches");

        repeat (4) begin
            issue(exec_op_pkg::op_jal, next_rand(), next_rand(), next_rand(), next_rand());
            issue(exec_op_pkg::op_jalr, next_rand(), next_rand(), next_rand(), next_rand());
        end
        idle();
        end_test("jal and jalr");

        foreach (mem_ops[i]) begin
            for (int t = 0; t < 4; t++) begin
                addr = next_rand();
                addr[SRAM_ADDR_W +: 2] = 2'(t);
                a = next_rand();
                spare = next_rand();
                // loads add src2, stores add imm
                if (mem_ops[i] inside {exec_op_pkg::op_sb, exec_op_pkg::op_sh,
                                       exec_op_pkg::op_sw}) begin
                    issue(mem_ops[i], a, spare, addr - a, next_rand());
                end else begin
                    issue(mem_ops[i], a, addr - a, spare, next_rand());
                end
            end
        end
        // a load that is not valid still shows on idu_ld_vld
        idu_vld = 1'b0;
        idu_op = exec_op_pkg::op_lw;
        @(negedge clk);
        idle();
        end_test("loads and stores");

        addr = next_rand();
        issue(exec_op_pkg::op_sw, 32'd0, next_rand(), addr, 32'd0);
        lsu_rdy = 1'b0;
        idu_vld = 1'b1;
        idu_op = exec_op_pkg::op_jal;
        repeat (4) @(negedge clk);
        idu_op = exec_op_pkg::op_sub;
        repeat (3) @(negedge clk);
        lsu_rdy = 1'b1;
        issue(exec_op_pkg::op_xor, next_rand(), next_rand(), 32'd0, 32'd0);
        lsu_rdy = 1'b0;
        repeat (3) @(negedge clk);
        lsu_rdy = 1'b1;
        idle();
        end_test("back-pressure");

        if (timed_out) begin
            $display("timeout: the DUT never accepted an instruction");
        end
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
